// File: rv_core_pkg.sv
// RV32I core shared types
`default_nettype none

package rv_core_pkg;

	typedef enum logic [2:0] {
		opc_arith,
		opc_shift_mul,
		opc_load,
		opc_store,
		opc_branch,
		opc_jal,
		opc_jalr,
		opc_lui
	} op_class_t;

	// Compare ops put their result in bit 0
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_eq,
		alu_ne,
		alu_lt,
		alu_ge,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		mds_sll,
		mds_srl,
		mds_sra,
		mds_mul
	} mds_op_t;

	typedef enum logic [2:0] {
		mem_lw,
		mem_lb,
		mem_lbu,
		mem_sw,
		mem_sb
	} mem_op_t;

	typedef struct packed {
		op_class_t   op_class;
		alu_op_t     alu_op;
		mds_op_t     mds_op;
		mem_op_t     mem_op;
		logic [4:0]  rd;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] store_data;
		logic [31:0] offset;
	} decoded_t;

	typedef struct packed {
		logic        wen;
		logic [4:0]  waddr;
		logic [31:0] wdata;
	} wb_t;

	typedef struct packed {
		logic        complete;
		logic [31:0] pc;
		logic        pc_seq;
	} retire_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
// Integer register file
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
	input  logic               clock,
	input  logic               reset,
	input  logic [4:0]         rs1,
	input  logic [4:0]         rs2,
	output logic [31:0]        rs1_data,
	output logic [31:0]        rs2_data,
	input  rv_core_pkg::wb_t   wb
);

	logic [31:0] regs [1:31];

	// x0 always reads as zero
	assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wb.wen && wb.waddr != 5'd0) begin
			regs[wb.waddr] <= wb.wdata;
		end
	end

	// Execute filters out rd == 0 before write-back
	assert property (@(posedge clock) disable iff (reset) wb.wen |-> wb.waddr != 5'd0);

endmodule

`default_nettype wire

// File: rv_decode.sv
// Instruction decode
`default_nettype none
`timescale 1ns/1ps

module rv_decode (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [31:0]             instr,
	input  logic                    instr_valid,
	output logic                    ready,
	output logic [4:0]              rs1,
	output logic [4:0]              rs2,
	input  logic [31:0]             rs1_data,
	input  logic [31:0]             rs2_data,
	input  logic                    retire_complete,
	output rv_core_pkg::decoded_t   decoded,
	output logic                    decode_valid
);
	import rv_core_pkg::*;

	decoded_t    next;
	logic        bad;
	logic        accept;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] imm_u;

	assign ready  = !decode_valid;
	assign accept = instr_valid && ready;
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};

	always_comb begin
		next.op_class   = opc_arith;
		next.alu_op     = alu_add;
		next.mds_op     = mds_sll;
		next.mem_op     = mem_lw;
		next.rd         = instr[11:7];
		next.op_a       = rs1_data;
		next.op_b       = rs2_data;
		next.store_data = rs2_data;
		next.offset     = imm_b;
		bad             = 1'b0;
		case (instr[6:0])
			7'b0110111: begin
				next.op_class = opc_lui;
				next.alu_op   = alu_pass_b;
				next.op_b     = imm_u;
			end
			// OP-IMM and OP share funct3 decoding, instr[5] selects register form
			7'b0010011, 7'b0110011: begin
				if (!instr[5]) begin
					next.op_b = imm_i;
				end
				if (instr[5] && instr[31:25] == 7'b0000001) begin
					next.op_class = opc_shift_mul;
					next.mds_op   = mds_mul;
					bad           = (funct3 != 3'b000);
				end else begin
					case (funct3)
						3'b000: next.alu_op = (instr[5] && instr[30]) ? alu_sub : alu_add;
						3'b001: next.op_class = opc_shift_mul;
						3'b010: next.alu_op = alu_slt;
						3'b011: next.alu_op = alu_sltu;
						3'b100: next.alu_op = alu_xor;
						3'b101: begin
							next.op_class = opc_shift_mul;
							next.mds_op   = instr[30] ? mds_sra : mds_srl;
						end
						3'b110: next.alu_op = alu_or;
						default: next.alu_op = alu_and;
					endcase
				end
			end
			7'b0000011: begin
				next.op_class = opc_load;
				next.op_b     = imm_i;
				case (funct3)
					3'b000: next.mem_op = mem_lb;
					3'b010: next.mem_op = mem_lw;
					3'b100: next.mem_op = mem_lbu;
					default: bad = 1'b1;
				endcase
			end
			7'b0100011: begin
				next.op_class = opc_store;
				next.op_b     = imm_s;
				next.rd       = 5'd0;
				case (funct3)
					3'b000: next.mem_op = mem_sb;
					3'b010: next.mem_op = mem_sw;
					default: bad = 1'b1;
				endcase
			end
			7'b1100011: begin
				next.op_class = opc_branch;
				next.rd       = 5'd0;
				case (funct3)
					3'b000: next.alu_op = alu_eq;
					3'b001: next.alu_op = alu_ne;
					3'b100: next.alu_op = alu_lt;
					3'b101: next.alu_op = alu_ge;
					default: bad = 1'b1;
				endcase
			end
			7'b1101111: begin
				next.op_class = opc_jal;
				next.offset   = imm_j;
			end
			7'b1100111: begin
				next.op_class = opc_jalr;
				next.offset   = imm_i;
				bad           = (funct3 != 3'b000);
			end
			default: bad = 1'b1;
		endcase
		// Anything unknown retires as a no-op
		if (bad) begin
			next.op_class = opc_arith;
			next.alu_op   = alu_add;
			next.rd       = 5'd0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decode_valid <= 1'b0;
		end else if (accept) begin
			decode_valid <= 1'b1;
		end else if (retire_complete) begin
			decode_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			decoded <= next;
		end
	end

endmodule

`default_nettype wire

// File: rv_alu.sv
// Single-cycle ALU
`default_nettype none
`timescale 1ns/1ps

module rv_alu (
	input  logic [31:0]          op_a,
	input  logic [31:0]          op_b,
	input  rv_core_pkg::alu_op_t op,
	output logic [31:0]          out
);
	import rv_core_pkg::*;

	always_comb begin
		case (op)
			alu_add:    out = op_a + op_b;
			alu_sub:    out = op_a - op_b;
			alu_and:    out = op_a & op_b;
			alu_or:     out = op_a | op_b;
			alu_xor:    out = op_a ^ op_b;
			alu_slt:    out = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_sltu:   out = {31'd0, op_a < op_b};
			alu_eq:     out = {31'd0, op_a == op_b};
			alu_ne:     out = {31'd0, op_a != op_b};
			alu_lt:     out = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_ge:     out = {31'd0, $signed(op_a) >= $signed(op_b)};
			alu_pass_b: out = op_b;
			default:    out = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// File: rv_mds.sv
// Multi-cycle shifter and multiplier
`default_nettype none
`timescale 1ns/1ps

module rv_mds #(
	parameter logic ENABLE_MUL = 1'b1
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [31:0]          in_a,
	input  logic [31:0]          in_b,
	input  rv_core_pkg::mds_op_t op,
	input  logic                 start,
	output logic [31:0]          out,
	output logic                 done
);
	import rv_core_pkg::*;

	logic        busy;
	logic [5:0]  count;
	mds_op_t     op_q;
	// Shift operand, or the multiplicand during MUL
	logic [31:0] value;
	logic [31:0] mplier;
	logic [31:0] acc;

	assign done = busy && count == 6'd0;
	assign out  = (op_q != mds_mul) ? value : (ENABLE_MUL ? acc : 32'd0);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= 1'b0;
			count <= 6'd0;
		end else if (start) begin
			busy  <= 1'b1;
			count <= (op == mds_mul) ? (ENABLE_MUL ? 6'd32 : 6'd0) : {1'b0, in_b[4:0]};
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			count <= count - 6'd1;
		end
	end

	// One bit position per cycle
	always_ff @(posedge clock) begin
		if (start) begin
			op_q   <= op;
			value  <= in_a;
			mplier <= in_b;
			acc    <= 32'd0;
		end else if (busy && count != 6'd0) begin
			case (op_q)
				mds_sll: value <= value << 1;
				mds_srl: value <= value >> 1;
				mds_sra: value <= {value[31], value[31:1]};
				default: begin
					if (mplier[0]) begin
						acc <= acc + value;
					end
					value  <= value << 1;
					mplier <= mplier >> 1;
				end
			endcase
		end
	end

	// Execute must wait for done before the next start
	assert property (@(posedge clock) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

// File: rv_mem.sv
// Load/store unit
`default_nettype none
`timescale 1ns/1ps

module rv_mem (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 req,
	input  logic [31:0]          addr,
	input  rv_core_pkg::mem_op_t mem_op,
	input  logic [31:0]          store_data,
	output logic                 ack,
	output logic [31:0]          load_data,
	output logic                 dvalid,
	output logic                 dwrite,
	output logic [31:0]          daddr,
	output logic [31:0]          dwdata,
	output logic [3:0]           dwstb,
	input  logic [31:0]          drdata,
	input  logic                 dready
);
	import rv_core_pkg::*;

	mem_op_t    op_q;
	logic [1:0] byte_sel;
	logic [7:0] ld_byte;

	assign ack     = dvalid && dready;
	assign ld_byte = drdata[8 * byte_sel +: 8];

	always_comb begin
		case (op_q)
			mem_lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
			mem_lbu: load_data = {24'd0, ld_byte};
			default: load_data = drdata;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dvalid <= 1'b0;
		end else if (req) begin
			dvalid <= 1'b1;
		end else if (ack) begin
			dvalid <= 1'b0;
		end
	end

	// Request fields held until the access completes
	always_ff @(posedge clock) begin
		if (req) begin
			op_q     <= mem_op;
			byte_sel <= addr[1:0];
			daddr    <= {addr[31:2], 2'b00};
			dwrite   <= (mem_op == mem_sw || mem_op == mem_sb);
			case (mem_op)
				mem_sw: begin
					dwdata <= store_data;
					dwstb  <= 4'b1111;
				end
				mem_sb: begin
					dwdata <= {4{store_data[7:0]}};
					dwstb  <= 4'b0001 << addr[1:0];
				end
				default: begin
					dwdata <= store_data;
					dwstb  <= 4'b0000;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable({dwrite, daddr, dwdata, dwstb}));

endmodule

`default_nettype wire

// File: rv_exec.sv
// Execute state machine
`default_nettype none
`timescale 1ns/1ps

module rv_exec #(
	parameter logic [31:0] RESET_PC   = 32'h8000_0000,
	parameter logic        ENABLE_MUL = 1'b1
) (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_core_pkg::decoded_t decoded,
	input  logic                  decode_valid,
	output rv_core_pkg::wb_t      wb,
	output rv_core_pkg::retire_t  retire,
	output logic                  dvalid,
	output logic                  dwrite,
	output logic [31:0]           daddr,
	output logic [31:0]           dwdata,
	output logic [3:0]            dwstb,
	input  logic [31:0]           drdata,
	input  logic                  dready
);
	import rv_core_pkg::*;

	typedef enum logic [2:0] {
		st_execute,
		st_branch_taken,
		st_jump,
		st_mds_wait,
		st_mem_wait
	} state_t;

	state_t      state;
	logic        complete;
	logic [31:0] pc;
	logic        pc_seq;
	logic        go;
	logic [31:0] pc_plus4;
	logic [31:0] target;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	alu_op_t     alu_op;
	logic [31:0] alu_out;
	logic        mds_start;
	logic        mds_done;
	logic [31:0] mds_out;
	logic        mem_req;
	logic        mem_ack;
	logic [31:0] load_data;

	// decode_valid is still high in the complete cycle
	assign go       = decode_valid && !complete;
	assign pc_plus4 = pc + 32'd4;
	assign retire   = '{complete: complete, pc: pc, pc_seq: pc_seq};

	// Target address, low bit cleared for JALR
	assign target = (decoded.op_class == opc_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

	assign alu_a = (state == st_branch_taken ||
		(state == st_jump && decoded.op_class == opc_jal)) ? pc : decoded.op_a;
	assign alu_b = (state == st_branch_taken || state == st_jump) ?
		decoded.offset : decoded.op_b;
	assign alu_op = (state == st_branch_taken || state == st_jump) ? alu_add : decoded.alu_op;

	assign mds_start = go && state == st_execute && decoded.op_class == opc_shift_mul;
	assign mem_req   = go && state == st_execute &&
		(decoded.op_class == opc_load || decoded.op_class == opc_store);

	always_comb begin
		wb.waddr = decoded.rd;
		case (decoded.op_class)
			opc_lui:           wb.wdata = decoded.op_b;
			opc_jal, opc_jalr: wb.wdata = pc_plus4;
			opc_shift_mul:     wb.wdata = mds_out;
			opc_load:          wb.wdata = load_data;
			default:           wb.wdata = alu_out;
		endcase
		case (state)
			st_execute: wb.wen = go && (decoded.op_class == opc_arith ||
				decoded.op_class == opc_lui || decoded.op_class == opc_jal ||
				decoded.op_class == opc_jalr);
			st_mds_wait: wb.wen = mds_done;
			st_mem_wait: wb.wen = mem_ack && decoded.op_class == opc_load;
			default:     wb.wen = 1'b0;
		endcase
		if (decoded.rd == 5'd0) begin
			wb.wen = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= st_execute;
			complete <= 1'b0;
			pc       <= RESET_PC;
			pc_seq   <= 1'b1;
		end else begin
			complete <= 1'b0;
			case (state)
				st_execute: begin
					if (go) begin
						case (decoded.op_class)
							opc_branch: begin
								if (alu_out[0]) begin
									state <= st_branch_taken;
								end else begin
									pc       <= pc_plus4;
									pc_seq   <= 1'b1;
									complete <= 1'b1;
								end
							end
							opc_jal, opc_jalr:   state <= st_jump;
							opc_shift_mul:       state <= st_mds_wait;
							opc_load, opc_store: state <= st_mem_wait;
							default: begin
								pc       <= pc_plus4;
								pc_seq   <= 1'b1;
								complete <= 1'b1;
							end
						endcase
					end
				end
				st_branch_taken, st_jump: begin
					pc       <= target;
					pc_seq   <= 1'b0;
					complete <= 1'b1;
					state    <= st_execute;
				end
				st_mds_wait, st_mem_wait: begin
					if ((state == st_mds_wait) ? mds_done : mem_ack) begin
						pc       <= pc_plus4;
						pc_seq   <= 1'b1;
						complete <= 1'b1;
						state    <= st_execute;
					end
				end
				default: state <= st_execute;
			endcase
		end
	end

	rv_alu i_alu (
		.op_a (alu_a),
		.op_b (alu_b),
		.op   (alu_op),
		.out  (alu_out)
	);

	rv_mds #(
		.ENABLE_MUL (ENABLE_MUL)
	) i_mds (
		.clock (clock),
		.reset (reset),
		.in_a  (decoded.op_a),
		.in_b  (decoded.op_b),
		.op    (decoded.mds_op),
		.start (mds_start),
		.out   (mds_out),
		.done  (mds_done)
	);

	rv_mem i_mem (
		.clock      (clock),
		.reset      (reset),
		.req        (mem_req),
		.addr       (alu_out),
		.mem_op     (decoded.mem_op),
		.store_data (decoded.store_data),
		.ack        (mem_ack),
		.load_data  (load_data),
		.dvalid     (dvalid),
		.dwrite     (dwrite),
		.daddr      (daddr),
		.dwdata     (dwdata),
		.dwstb      (dwstb),
		.drdata     (drdata),
		.dready     (dready)
	);

endmodule

`default_nettype wire

// File: rv_core.sv
// RV32I subset core top level
`default_nettype none
`timescale 1ns/1ps

module rv_core #(
	parameter logic [31:0] RESET_PC   = 32'h8000_0000,
	parameter logic        ENABLE_MUL = 1'b1
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [31:0]          instr,
	input  logic                 instr_valid,
	output logic                 ready,
	output logic                 dvalid,
	output logic                 dwrite,
	output logic [31:0]          daddr,
	output logic [31:0]          dwdata,
	output logic [3:0]           dwstb,
	input  logic [31:0]          drdata,
	input  logic                 dready,
	output rv_core_pkg::wb_t     wb,
	output rv_core_pkg::retire_t retire
);
	import rv_core_pkg::*;

	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	decoded_t    decoded;
	logic        decode_valid;

	rv_decode i_decode (
		.clock           (clock),
		.reset           (reset),
		.instr           (instr),
		.instr_valid     (instr_valid),
		.ready           (ready),
		.rs1             (rs1),
		.rs2             (rs2),
		.rs1_data        (rs1_data),
		.rs2_data        (rs2_data),
		.retire_complete (retire.complete),
		.decoded         (decoded),
		.decode_valid    (decode_valid)
	);

	rv_regfile i_regfile (
		.clock    (clock),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	rv_exec #(
		.RESET_PC   (RESET_PC),
		.ENABLE_MUL (ENABLE_MUL)
	) i_exec (
		.clock        (clock),
		.reset        (reset),
		.decoded      (decoded),
		.decode_valid (decode_valid),
		.wb           (wb),
		.retire       (retire),
		.dvalid       (dvalid),
		.dwrite       (dwrite),
		.daddr        (daddr),
		.dwdata       (dwdata),
		.dwstb        (dwstb),
		.drdata       (drdata),
		.dready       (dready)
	);

endmodule

`default_nettype wire

// File: tb_rv_core.sv
// RV32I core directed testbench
`default_nettype none
`timescale 1ns/1ps

module tb_rv_core;
	import rv_core_pkg::*;

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;

	logic        clock;
	logic        reset;
	logic [31:0] instr;
	logic        instr_valid;
	logic        ready;
	logic        dvalid;
	logic        dwrite;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [3:0]  dwstb;
	logic [31:0] drdata;
	logic        dready;
	wb_t         wb;
	retire_t     retire;

	// Reference model state
	logic [31:0] ref_regs [32];
	logic [31:0] ref_pc;
	logic [31:0] ref_mem [256];

	// Data memory model
	logic [31:0] mem [256];
	int          mem_delay;
	int          wait_left;
	logic        mem_busy;
	logic [7:0]  mem_idx;
	logic        wr_seen;
	logic [31:0] wr_addr;
	logic [3:0]  wr_stb;
	logic [31:0] wr_data;

	// Last write-back and retire seen on the outputs
	logic        wb_seen;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        retire_seen;
	logic [31:0] retire_pc;
	logic        retire_seq;

	rv_core i_rv_core (
		.clock       (clock),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ready       (ready),
		.dvalid      (dvalid),
		.dwrite      (dwrite),
		.daddr       (daddr),
		.dwdata      (dwdata),
		.dwstb       (dwstb),
		.drdata      (drdata),
		.dready      (dready),
		.wb          (wb),
		.retire      (retire)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] fill_word(input int idx);
		return 32'h6b8b_4567 ^ (32'(idx) * 32'h0001_0003) ^ {8'(idx), 24'd0};
	endfunction

	// Answers each request after mem_delay cycles
	always @(posedge clock) begin
		#10;
		if (dready) begin
			dready   = 1'b0;
			mem_busy = 1'b0;
		end else if (dvalid && !reset) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				wait_left = mem_delay;
			end
			if (wait_left == 0) begin
				mem_idx = daddr[9:2];
				if (dwrite) begin
					for (int b = 0; b < 4; b++) begin
						if (dwstb[b]) begin
							mem[mem_idx][8 * b +: 8] = dwdata[8 * b +: 8];
						end
					end
					wr_seen = 1'b1;
					wr_addr = daddr;
					wr_stb  = dwstb;
					wr_data = dwdata;
				end else begin
					drdata = mem[mem_idx];
				end
				dready = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	always @(negedge clock) begin
		if (wb.wen) begin
			wb_seen = 1'b1;
			wb_addr = wb.waddr;
			wb_data = wb.wdata;
		end
		if (retire.complete) begin
			retire_seen = 1'b1;
			retire_pc   = retire.pc;
			retire_seq  = retire.pc_seq;
		end
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// Expected result of the RV32I OP and OP-IMM functions
	function automatic logic [31:0] expect_arith(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s, got 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic issue_instr(input logic [31:0] word);
		int cycles;
		cycles = 0;
		while (ready !== 1'b1) begin
			@(posedge clock);
			#10;
			cycles++;
			if (cycles > 20) begin
				$display("Timeout at %0d ns: the core never raised ready", $time);
				abort_run();
			end
		end
		wb_seen     = 1'b0;
		retire_seen = 1'b0;
		mem_delay   = $urandom_range(3, 0);
		instr       = word;
		instr_valid = 1'b1;
		@(posedge clock);
		#10;
		instr_valid = 1'b0;
		instr       = 32'd0;
		cycles      = 0;
		while (!retire_seen) begin
			@(posedge clock);
			#10;
			cycles++;
			if (cycles > 100) begin
				$display("Timeout at %0d ns: instruction %08h never retired", $time, word);
				abort_run();
			end
		end
	endtask

	// Runs one instruction and checks write-back and retire against the reference
	task automatic execute_and_check(input logic [31:0] word, input logic [4:0] rd,
			input logic [31:0] data, input logic [31:0] next_pc, input logic seq);
		issue_instr(word);
		if (rd != 5'd0) begin
			check_value(32'(wb_seen), 32'd1, "write-back missing");
			check_value(32'(wb_addr), 32'(rd), "wb.waddr");
			check_value(wb_data, data, "wb.wdata");
			ref_regs[rd] = data;
		end else begin
			check_value(32'(wb_seen), 32'd0, "unexpected write-back");
		end
		check_value(retire_pc, next_pc, "retire.pc");
		check_value(32'(retire_seq), 32'(seq), "retire.pc_seq");
		ref_pc = next_pc;
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		logic [19:0] hi;
		hi = value[31:12] + 20'(value[11]);
		execute_and_check({hi, rd, op_lui}, rd, {hi, 12'd0}, ref_pc + 32'd4, 1'b1);
		execute_and_check(enc_i(value[11:0], rd, 3'b000, rd, op_imm), rd, value,
			ref_pc + 32'd4, 1'b1);
	endtask

	task automatic reset_state();
		check_value(32'(ready), 32'd1, "ready after reset");
		check_value(32'(dvalid), 32'd0, "dvalid after reset");
		check_value(32'(retire.complete), 32'd0, "retire.complete after reset");
		check_value(retire.pc, 32'h8000_0000, "pc after reset");
		check_value(32'(retire.pc_seq), 32'd1, "pc_seq after reset");
		execute_and_check(enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_imm), 5'd0, 32'd0,
			ref_pc + 32'd4, 1'b1);
	endtask

	task automatic arith_and_lui();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [2:0]  f3;
		for (int n = 0; n < 4; n++) begin
			a   = $urandom;
			b   = $urandom;
			imm = 12'($urandom);
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			for (int k = 0; k < 8; k++) begin
				f3 = k[2:0];
				if (k != 1 && k != 5) begin
					execute_and_check(enc_r(7'h00, 5'd2, 5'd1, f3, 5'd3), 5'd3,
						expect_arith(f3, 1'b0, a, b), ref_pc + 32'd4, 1'b1);
					execute_and_check(enc_i(imm, 5'd1, f3, 5'd4, op_imm), 5'd4,
						expect_arith(f3, 1'b0, a, sext12(imm)), ref_pc + 32'd4, 1'b1);
				end
			end
			execute_and_check(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3,
				expect_arith(3'b000, 1'b1, a, b), ref_pc + 32'd4, 1'b1);
		end
		// A write to x0 is dropped and x0 still reads as zero
		execute_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 5'd0, 32'd0,
			ref_pc + 32'd4, 1'b1);
		execute_and_check(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd5), 5'd5, ref_regs[1],
			ref_pc + 32'd4, 1'b1);
	endtask

	task automatic shifts_and_mul();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sra_val;
		logic [4:0]  sh;
		for (int n = 0; n < 6; n++) begin
			a  = $urandom;
			b  = $urandom;
			sh = 5'($urandom);
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			execute_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 5'd3, a << b[4:0],
				ref_pc + 32'd4, 1'b1);
			execute_and_check(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, a >> b[4:0],
				ref_pc + 32'd4, 1'b1);
			sra_val = $signed(a) >>> b[4:0];
			execute_and_check(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, sra_val,
				ref_pc + 32'd4, 1'b1);
			execute_and_check(enc_i({7'h00, sh}, 5'd1, 3'b001, 5'd4, op_imm), 5'd4, a << sh,
				ref_pc + 32'd4, 1'b1);
			execute_and_check(enc_i({7'h00, sh}, 5'd1, 3'b101, 5'd4, op_imm), 5'd4, a >> sh,
				ref_pc + 32'd4, 1'b1);
			sra_val = $signed(a) >>> sh;
			execute_and_check(enc_i({7'h20, sh}, 5'd1, 3'b101, 5'd4, op_imm), 5'd4, sra_val,
				ref_pc + 32'd4, 1'b1);
			execute_and_check(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd6), 5'd6, a * b,
				ref_pc + 32'd4, 1'b1);
		end
	endtask

	task automatic loads_and_stores();
		logic [31:0] base;
		logic [31:0] addr;
		logic [7:0]  idx;
		logic [1:0]  lane;
		logic [7:0]  byte_val;
		logic [11:0] off;
		for (int n = 0; n < 8; n++) begin
			base = 32'h0000_1000 | ($urandom & 32'h0000_03fc);
			load_reg(5'd5, base);
			load_reg(5'd6, $urandom);
			off  = 12'($urandom_range(7, 0) * 4);
			addr = base + sext12(off);
			idx  = addr[9:2];
			wr_seen = 1'b0;
			execute_and_check(enc_s(off, 5'd6, 5'd5, 3'b010), 5'd0, 32'd0, ref_pc + 32'd4, 1'b1);
			check_value(32'(wr_seen), 32'd1, "SW reached the bus");
			check_value(wr_addr, addr, "SW daddr");
			check_value(32'(wr_stb), 32'hf, "SW dwstb");
			check_value(wr_data, ref_regs[6], "SW dwdata");
			ref_mem[idx] = ref_regs[6];
			lane = 2'($urandom);
			wr_seen = 1'b0;
			execute_and_check(enc_s(off + 12'(lane), 5'd6, 5'd5, 3'b000), 5'd0, 32'd0,
				ref_pc + 32'd4, 1'b1);
			check_value(32'(wr_seen), 32'd1, "SB reached the bus");
			check_value(wr_addr, addr, "SB daddr");
			check_value(32'(wr_stb), 32'(4'b0001 << lane), "SB dwstb");
			check_value(wr_data, {4{ref_regs[6][7:0]}}, "SB dwdata");
			ref_mem[idx][8 * lane +: 8] = ref_regs[6][7:0];
			execute_and_check(enc_i(off, 5'd5, 3'b010, 5'd7, op_load), 5'd7, ref_mem[idx],
				ref_pc + 32'd4, 1'b1);
			// Byte loads anywhere in a 64-byte window including untouched words
			off      = 12'($urandom_range(63, 0));
			addr     = base + sext12(off);
			idx      = addr[9:2];
			byte_val = ref_mem[idx][8 * addr[1:0] +: 8];
			execute_and_check(enc_i(off, 5'd5, 3'b000, 5'd8, op_load), 5'd8,
				{{24{byte_val[7]}}, byte_val}, ref_pc + 32'd4, 1'b1);
			execute_and_check(enc_i(off, 5'd5, 3'b100, 5'd9, op_load), 5'd9,
				{24'd0, byte_val}, ref_pc + 32'd4, 1'b1);
		end
	endtask

	task automatic branches_and_jumps();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] off;
		logic [11:0] imm;
		logic [2:0]  f3;
		logic        taken;
		for (int p = 0; p < 3; p++) begin
			a = $urandom;
			b = a;
			if (p == 1) begin
				a = a | 32'h8000_0000;
				b = $urandom & 32'h7fff_ffff;
			end else if (p == 2) begin
				a = a & 32'h7fff_ffff;
				b = $urandom | 32'h8000_0000;
			end
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			for (int k = 0; k < 8; k++) begin
				f3 = k[2:0];
				if (k == 0 || k == 1 || k == 4 || k == 5) begin
					off = $urandom_range(1023, 4) * 2;
					if ($urandom_range(1, 0) == 1) begin
						off = -off;
					end
					case (f3)
						3'b000: taken = (a == b);
						3'b001: taken = (a != b);
						3'b100: taken = ($signed(a) < $signed(b));
						default: taken = ($signed(a) >= $signed(b));
					endcase
					execute_and_check(enc_b(off[12:0], 5'd2, 5'd1, f3), 5'd0, 32'd0,
						taken ? ref_pc + off : ref_pc + 32'd4, !taken);
				end
			end
		end
		off = $urandom_range(100000, 4) * 2;
		if ($urandom_range(1, 0) == 1) begin
			off = -off;
		end
		execute_and_check(enc_j(off[20:0], 5'd7), 5'd7, ref_pc + 32'd4, ref_pc + off, 1'b0);
		a   = $urandom;
		imm = 12'($urandom);
		// Odd sum so the cleared low bit of the target shows
		imm[0] = ~a[0];
		load_reg(5'd1, a);
		execute_and_check(enc_i(imm, 5'd1, 3'b000, 5'd8, op_jalr), 5'd8, ref_pc + 32'd4,
			(a + sext12(imm)) & ~32'd1, 1'b0);
	endtask

	initial begin
		void'($urandom(74));
		reset       = 1'b1;
		instr       = 32'd0;
		instr_valid = 1'b0;
		drdata      = 32'd0;
		dready      = 1'b0;
		mem_delay   = 0;
		wait_left   = 0;
		mem_busy    = 1'b0;
		wr_seen     = 1'b0;
		wb_seen     = 1'b0;
		retire_seen = 1'b0;
		ref_pc      = 32'h8000_0000;
		for (int i = 0; i < 256; i++) begin
			mem[i]     = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = 32'd0;
		end
		repeat (8) @(posedge clock);
		#10;
		reset = 1'b0;
		reset_state();
		arith_and_lui();
		shifts_and_mul();
		loads_and_stores();
		branches_and_jumps();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rv_core_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_alu.sv
rv_mds.sv
rv_mem.sv
rv_exec.sv
rv_core.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_rv_core -f compile.f -Mdir obj_dir || exit 1
./obj_dir/Vtb_rv_core > sim.log 2>&1 ; cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || grep -q "Test OK" sim.log
